//--- project.f
source/io_hub_pkg.sv
source/tick_timer.sv
source/sys_ctrl_regs.sv
source/io_decode.sv
source/axil_target.sv
source/io_hub_top.sv
test/io_hub_sva.sv
test/tb_io_hub.sv

//--- run_sim.sh
#!/bin/sh
# build and run the io hub testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_io_hub \
	--Mdir obj_dir -o tb_io_hub
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_io_hub > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
	echo "simulation FAILED"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
echo "simulation passed"
exit 0

//--- source/axil_target.sv
`timescale 1ns/1ns

module axil_target (
	input  logic                  clk100,
	input  logic                  rst,
	input  io_hub_pkg::bus_addr_t s_axil_awaddr_i,
	input  logic                  s_axil_awvalid_i,
	output logic                  s_axil_awready_o,
	input  io_hub_pkg::bus_data_t s_axil_wdata_i,
	input  io_hub_pkg::bus_strb_t s_axil_wstrb_i,
	input  logic                  s_axil_wvalid_i,
	output logic                  s_axil_wready_o,
	output io_hub_pkg::bus_resp_t s_axil_bresp_o,
	output logic                  s_axil_bvalid_o,
	input  logic                  s_axil_bready_i,
	input  io_hub_pkg::bus_addr_t s_axil_araddr_i,
	input  logic                  s_axil_arvalid_i,
	output logic                  s_axil_arready_o,
	output io_hub_pkg::bus_data_t s_axil_rdata_o,
	output io_hub_pkg::bus_resp_t s_axil_rresp_o,
	output logic                  s_axil_rvalid_o,
	input  logic                  s_axil_rready_i,
	output io_hub_pkg::io_req_t   req_o,	// to decoder
	input  io_hub_pkg::io_rsp_t   rsp_i
);
	import io_hub_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,	// nothing outstanding
		ST_ISSUE,	// request on req_o
		ST_WAIT,	// decoder working
		ST_RESP	// b or r channel valid
	} state_t;

	state_t    state;
	logic      is_wr;	// outstanding op is a write
	bus_addr_t aw_addr_q;	// write address
	bus_data_t w_data_q;	// write data, held apart from the address
	bus_strb_t w_strb_q;
	bus_addr_t ar_addr_q;
	bus_data_t rdata_q;
	bus_resp_t resp_q;
	logic      wr_accept;
	logic      rd_accept;
	logic      rsp_taken;

	// --------------------------------------------------
	// acceptance, writes win
	// --------------------------------------------------
	// both write channels must be up, so they complete together
	assign wr_accept = (state == ST_IDLE) & s_axil_awvalid_i & s_axil_wvalid_i;
	// a half-present write still blocks reads
	assign rd_accept = (state == ST_IDLE) & s_axil_arvalid_i
		& ~s_axil_awvalid_i & ~s_axil_wvalid_i;

	assign s_axil_awready_o = wr_accept;
	assign s_axil_wready_o  = wr_accept;	// same pulse as awready
	assign s_axil_arready_o = rd_accept;

	assign rsp_taken = is_wr ? s_axil_bready_i : s_axil_rready_i;

	always_ff @(posedge clk100) begin
		if (rst) begin
			state <= ST_IDLE;
			is_wr <= 1'b0;
		end else begin
			case (state)
			ST_IDLE: begin
				if (wr_accept) begin
					state <= ST_ISSUE;
					is_wr <= 1'b1;
				end else if (rd_accept) begin
					state <= ST_ISSUE;
					is_wr <= 1'b0;
				end
			end
			ST_ISSUE: state <= ST_WAIT;	// req valid for this one cycle
			ST_WAIT: begin
				if (rsp_i.valid)
					state <= ST_RESP;
			end
			ST_RESP: begin
				if (rsp_taken)
					state <= ST_IDLE;	// held until master takes it
			end
			default: state <= ST_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// payload capture
	// --------------------------------------------------
	always_ff @(posedge clk100) begin
		if (wr_accept) begin
			aw_addr_q <= s_axil_awaddr_i;
			w_data_q  <= s_axil_wdata_i;
			w_strb_q  <= s_axil_wstrb_i;
		end
		if (rd_accept)
			ar_addr_q <= s_axil_araddr_i;
		if (state == ST_WAIT && rsp_i.valid) begin
			rdata_q <= rsp_i.rdata;
			resp_q  <= rsp_i.resp;
		end
	end

	always_comb begin
		req_o.valid = (state == ST_ISSUE);
		req_o.wr    = is_wr;
		req_o.addr  = is_wr ? aw_addr_q : ar_addr_q;
		req_o.wdata = w_data_q;
		req_o.strb  = is_wr ? w_strb_q : 4'h0;	// reads carry no lanes
	end

	// response channels share the captured word
	assign s_axil_bvalid_o = (state == ST_RESP) & is_wr;
	assign s_axil_bresp_o  = resp_q;
	assign s_axil_rvalid_o = (state == ST_RESP) & ~is_wr;
	assign s_axil_rresp_o  = resp_q;
	assign s_axil_rdata_o  = rdata_q;

endmodule

//--- source/io_decode.sv
`timescale 1ns/1ns

module io_decode (
	input  logic                  clk100,
	input  logic                  rst,
	input  io_hub_pkg::io_req_t   req_i,
	output io_hub_pkg::io_rsp_t   rsp_o,
	output logic                  led_sel_o,
	output logic                  sysctrl_sel_o,
	output logic                  wr_o,
	output io_hub_pkg::bus_data_t wdata_o,
	output io_hub_pkg::bus_strb_t strb_o,
	input  io_hub_pkg::bus_data_t regs_rdata_i	// combinational read word
);
	import io_hub_pkg::*;

	page_t     page;
	logic      led_hit;
	logic      sys_hit;
	logic      any_hit;
	logic      rsp_valid;
	bus_data_t rsp_rdata;
	bus_resp_t rsp_resp;

	// --------------------------------------------------
	// page decode
	// --------------------------------------------------
	assign page    = req_i.addr[31:8];	// 256 byte pages
	assign led_hit = (page == PAGE_LED);
	assign sys_hit = (page == PAGE_SYSCTRL);
	assign any_hit = led_hit | sys_hit;

	// selects live only for the request cycle
	assign led_sel_o     = req_i.valid & led_hit;
	assign sysctrl_sel_o = req_i.valid & sys_hit;

	assign wr_o    = req_i.wr;
	assign wdata_o = req_i.wdata;
	assign strb_o  = req_i.strb;

	// --------------------------------------------------
	// registered response, one cycle behind
	// --------------------------------------------------
	always_ff @(posedge clk100) begin
		if (rst)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= req_i.valid;
	end

	always_ff @(posedge clk100) begin
		if (req_i.valid) begin
			// zero data on writes and on a miss
			if (any_hit && !req_i.wr)
				rsp_rdata <= regs_rdata_i;
			else
				rsp_rdata <= '0;
			rsp_resp <= any_hit ? RESP_OKAY : RESP_SLVERR;	// decode error
		end
	end

	always_comb begin
		rsp_o.valid = rsp_valid;
		rsp_o.rdata = rsp_rdata;
		rsp_o.resp  = rsp_resp;
	end

endmodule

//--- source/io_hub_pkg.sv
package io_hub_pkg;

	// --------------------------------------------------
	// bus level types
	// --------------------------------------------------
	typedef logic [31:0] bus_addr_t;	// byte address
	typedef logic [31:0] bus_data_t;
	typedef logic [3:0]  bus_strb_t;	// one bit per byte lane
	typedef logic [1:0]  bus_resp_t;

	localparam bus_resp_t RESP_OKAY   = 2'b00;
	localparam bus_resp_t RESP_SLVERR = 2'b10;

	// --------------------------------------------------
	// register types
	// --------------------------------------------------
	typedef logic [7:0]  led_t;
	typedef logic [15:0] core_mask_t;	// one reset request per core
	typedef logic [15:0] clken_t;

	// cores 1 and 2 clocked out of reset
	localparam clken_t CLKEN_RESET = 16'h0006;

	// io pages, named by address bits 31:8
	typedef logic [23:0] page_t;

	localparam page_t PAGE_LED     = 24'hFD0FFF;
	localparam page_t PAGE_SYSCTRL = 24'hFD0FFC;

	// --------------------------------------------------
	// internal request / response
	// --------------------------------------------------
	typedef struct packed {
		logic      valid;	// one cycle per transaction
		logic      wr;
		bus_addr_t addr;
		bus_data_t wdata;
		bus_strb_t strb;
	} io_req_t;

	typedef struct packed {
		logic      valid;
		bus_data_t rdata;
		bus_resp_t resp;
	} io_rsp_t;

endpackage

//--- source/io_hub_top.sv
`timescale 1ns/1ns

module io_hub_top #(
	parameter int RST_PULSE_LEN = 64,
	parameter int TMR_PERIOD    = 1000000,	// ticks per interrupt period
	parameter int TMR_ON        = 150,
	parameter int TMR_OFF       = 200
) (
	input  logic                   clk100,
	input  logic                   rst,
	// write address
	input  io_hub_pkg::bus_addr_t  s_axil_awaddr_i,
	input  logic                   s_axil_awvalid_i,
	output logic                   s_axil_awready_o,
	// write data
	input  io_hub_pkg::bus_data_t  s_axil_wdata_i,
	input  io_hub_pkg::bus_strb_t  s_axil_wstrb_i,
	input  logic                   s_axil_wvalid_i,
	output logic                   s_axil_wready_o,
	// write response
	output io_hub_pkg::bus_resp_t  s_axil_bresp_o,
	output logic                   s_axil_bvalid_o,
	input  logic                   s_axil_bready_i,
	// read address
	input  io_hub_pkg::bus_addr_t  s_axil_araddr_i,
	input  logic                   s_axil_arvalid_i,
	output logic                   s_axil_arready_o,
	// read data
	output io_hub_pkg::bus_data_t  s_axil_rdata_o,
	output io_hub_pkg::bus_resp_t  s_axil_rresp_o,
	output logic                   s_axil_rvalid_o,
	input  logic                   s_axil_rready_i,
	// io outputs
	output io_hub_pkg::led_t       led_o,
	output io_hub_pkg::core_mask_t core_rst_o,
	output io_hub_pkg::clken_t     clken_o,
	output logic                   tmr_irq_o
);
	import io_hub_pkg::*;

	io_req_t   req;	// target -> decoder
	io_rsp_t   rsp;	// decoder -> target
	logic      led_sel;
	logic      sysctrl_sel;
	logic      wr;
	bus_data_t wdata;
	bus_strb_t strb;
	bus_data_t regs_rdata;

	axil_target i_axil_target (
		.clk100           (clk100),
		.rst              (rst),
		.s_axil_awaddr_i  (s_axil_awaddr_i),
		.s_axil_awvalid_i (s_axil_awvalid_i),
		.s_axil_awready_o (s_axil_awready_o),
		.s_axil_wdata_i   (s_axil_wdata_i),
		.s_axil_wstrb_i   (s_axil_wstrb_i),
		.s_axil_wvalid_i  (s_axil_wvalid_i),
		.s_axil_wready_o  (s_axil_wready_o),
		.s_axil_bresp_o   (s_axil_bresp_o),
		.s_axil_bvalid_o  (s_axil_bvalid_o),
		.s_axil_bready_i  (s_axil_bready_i),
		.s_axil_araddr_i  (s_axil_araddr_i),
		.s_axil_arvalid_i (s_axil_arvalid_i),
		.s_axil_arready_o (s_axil_arready_o),
		.s_axil_rdata_o   (s_axil_rdata_o),
		.s_axil_rresp_o   (s_axil_rresp_o),
		.s_axil_rvalid_o  (s_axil_rvalid_o),
		.s_axil_rready_i  (s_axil_rready_i),
		.req_o            (req),
		.rsp_i            (rsp)
	);

	io_decode i_io_decode (
		.clk100        (clk100),
		.rst           (rst),
		.req_i         (req),
		.rsp_o         (rsp),
		.led_sel_o     (led_sel),
		.sysctrl_sel_o (sysctrl_sel),
		.wr_o          (wr),
		.wdata_o       (wdata),
		.strb_o        (strb),
		.regs_rdata_i  (regs_rdata)
	);

	sys_ctrl_regs #(
		.RST_PULSE_LEN (RST_PULSE_LEN)
	) i_sys_ctrl_regs (
		.clk100        (clk100),
		.rst           (rst),
		.led_sel_i     (led_sel),
		.sysctrl_sel_i (sysctrl_sel),
		.wr_i          (wr),
		.wdata_i       (wdata),
		.strb_i        (strb),
		.rdata_o       (regs_rdata),
		.led_o         (led_o),
		.core_rst_o    (core_rst_o),
		.clken_o       (clken_o)
	);

	// free running, no bus access
	tick_timer #(
		.TMR_PERIOD (TMR_PERIOD),
		.TMR_ON     (TMR_ON),
		.TMR_OFF    (TMR_OFF)
	) i_tick_timer (
		.clk100    (clk100),
		.rst       (rst),
		.tmr_irq_o (tmr_irq_o)
	);

endmodule

//--- source/sys_ctrl_regs.sv
`timescale 1ns/1ns

module sys_ctrl_regs #(
	parameter int RST_PULSE_LEN = 64	// cycles per core reset pulse
) (
	input  logic                   clk100,
	input  logic                   rst,
	input  logic                   led_sel_i,
	input  logic                   sysctrl_sel_i,
	input  logic                   wr_i,
	input  io_hub_pkg::bus_data_t  wdata_i,
	input  io_hub_pkg::bus_strb_t  strb_i,
	output io_hub_pkg::bus_data_t  rdata_o,
	output io_hub_pkg::led_t       led_o,
	output io_hub_pkg::core_mask_t core_rst_o,
	output io_hub_pkg::clken_t     clken_o
);
	import io_hub_pkg::*;

	// one spare bit so the count can sit at RST_PULSE_LEN
	localparam int CNT_W = $clog2(RST_PULSE_LEN) + 1;

	logic [CNT_W-1:0] rst_cnt;
	logic             pulse_on;
	logic             led_wr;
	logic             sys_wr;
	led_t             led_q;
	core_mask_t       rst_mask;
	core_mask_t       rsts;	// live pulse mask
	clken_t           clken_q;

	assign led_wr   = led_sel_i & wr_i;
	assign sys_wr   = sysctrl_sel_i & wr_i;
	assign pulse_on = (rst_cnt < CNT_W'(RST_PULSE_LEN));
	assign rsts     = pulse_on ? rst_mask : '0;

	// --------------------------------------------------
	// led register
	// --------------------------------------------------
	always_ff @(posedge clk100) begin
		if (rst)
			led_q <= '0;
		else if (led_wr && strb_i[0])
			led_q <= wdata_i[7:0];	// low lane only
	end

	// --------------------------------------------------
	// core reset mask, pulse counter, clock enables
	// --------------------------------------------------
	always_ff @(posedge clk100) begin
		if (rst) begin
			rst_cnt  <= CNT_W'(RST_PULSE_LEN);	// idle, no pulse
			rst_mask <= '0;
			clken_q  <= CLKEN_RESET;
		end else begin
			if (pulse_on)
				rst_cnt <= rst_cnt + 1'b1;
			else
				rst_mask <= '0;	// pulse over
			if (sys_wr && (strb_i[0] || strb_i[1])) begin
				rst_mask   <= wdata_i[15:0];
				rst_cnt    <= '0;	// restart pulse
				// resetting cores 4/5 turns their clock on
				clken_q[2] <= clken_q[2] | (|wdata_i[5:4]);
			end
			// upper lanes overwrite, so this beats the set above
			if (sys_wr && (strb_i[2] || strb_i[3]))
				clken_q[2:0] <= wdata_i[18:16];
		end
	end

	// read mux, no register here, decoder latches it
	always_comb begin
		if (led_sel_i)
			rdata_o = {24'h000000, led_q};
		else if (sysctrl_sel_i)
			rdata_o = {clken_q, rsts};
		else
			rdata_o = '0;
	end

	assign led_o      = led_q;
	assign core_rst_o = rsts;
	assign clken_o    = clken_q;	// plain outputs, gating is elsewhere

endmodule

//--- source/tick_timer.sv
`timescale 1ns/1ns

module tick_timer #(
	parameter int TMR_PERIOD = 1000000,	// count wraps after this
	parameter int TMR_ON     = 150,	// irq rises here
	parameter int TMR_OFF    = 200	// and falls here
) (
	input  logic clk100,
	input  logic rst,
	output logic tmr_irq_o
);

	localparam int CNT_W = $clog2(TMR_PERIOD + 1);

	logic [CNT_W-1:0] icnt;
	logic             irq_q;

	// --------------------------------------------------
	// period counter, runs 1 .. TMR_PERIOD
	// --------------------------------------------------
	always_ff @(posedge clk100) begin
		if (rst) begin
			icnt  <= CNT_W'(1);
			irq_q <= 1'b0;
		end else begin
			if (icnt == CNT_W'(TMR_PERIOD))
				icnt <= CNT_W'(1);	// wrap
			else
				icnt <= icnt + 1'b1;
			// window is TMR_OFF - TMR_ON cycles wide
			if (icnt == CNT_W'(TMR_ON))
				irq_q <= 1'b1;
			else if (icnt == CNT_W'(TMR_OFF))
				irq_q <= 1'b0;
		end
	end

	assign tmr_irq_o = irq_q;

endmodule

//--- test/io_hub_sva.sv
`timescale 1ns/1ns

module io_hub_sva #(
	parameter int RST_PULSE_LEN = 64
) (
	input logic                   clk100,
	input logic                   rst,
	input logic                   awvalid_i,
	input logic                   awready_i,
	input logic                   wvalid_i,
	input logic                   wready_i,
	input logic                   bvalid_i,
	input logic                   bready_i,
	input io_hub_pkg::bus_resp_t  bresp_i,
	input logic                   arvalid_i,
	input logic                   arready_i,
	input logic                   rvalid_i,
	input logic                   rready_i,
	input io_hub_pkg::bus_data_t  rdata_i,
	input io_hub_pkg::bus_resp_t  rresp_i,
	input io_hub_pkg::core_mask_t core_rst_i
);
	import io_hub_pkg::*;

	logic wr_pend;	// write accepted, b not yet taken
	logic rd_pend;
	int   rst_run;	// consecutive nonzero core_rst cycles

	always_ff @(posedge clk100) begin
		if (rst) begin
			wr_pend <= 1'b0;
			rd_pend <= 1'b0;
			rst_run <= 0;
		end else begin
			if (awvalid_i && awready_i && wvalid_i && wready_i)
				wr_pend <= 1'b1;
			else if (bvalid_i && bready_i)
				wr_pend <= 1'b0;
			if (arvalid_i && arready_i)
				rd_pend <= 1'b1;
			else if (rvalid_i && rready_i)
				rd_pend <= 1'b0;
			rst_run <= (core_rst_i != '0) ? rst_run + 1 : 0;
		end
	end

	// --------------------------------------------------
	// channel rules
	// --------------------------------------------------
	b_hold: assert property (@(posedge clk100) disable iff (rst)
		bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
	else $error("bvalid dropped or bresp changed before bready");

	r_hold: assert property (@(posedge clk100) disable iff (rst)
		rvalid_i && !rready_i |=> rvalid_i && $stable(rresp_i) && $stable(rdata_i))
	else $error("rvalid dropped or read data changed before rready");

	b_needs_req: assert property (@(posedge clk100) disable iff (rst) bvalid_i |-> wr_pend)
	else $error("write response without an accepted write");

	r_needs_req: assert property (@(posedge clk100) disable iff (rst) rvalid_i |-> rd_pend)
	else $error("read response without an accepted read");

	pulse_max: assert property (@(posedge clk100) disable iff (rst) rst_run <= RST_PULSE_LEN)
	else $error("core_rst_o held nonzero longer than the pulse length");

endmodule

bind io_hub_top io_hub_sva #(
	.RST_PULSE_LEN (RST_PULSE_LEN)
) i_io_hub_sva (
	.clk100     (clk100),
	.rst        (rst),
	.awvalid_i  (s_axil_awvalid_i),
	.awready_i  (s_axil_awready_o),
	.wvalid_i   (s_axil_wvalid_i),
	.wready_i   (s_axil_wready_o),
	.bvalid_i   (s_axil_bvalid_o),
	.bready_i   (s_axil_bready_i),
	.bresp_i    (s_axil_bresp_o),
	.arvalid_i  (s_axil_arvalid_i),
	.arready_i  (s_axil_arready_o),
	.rvalid_i   (s_axil_rvalid_o),
	.rready_i   (s_axil_rready_i),
	.rdata_i    (s_axil_rdata_o),
	.rresp_i    (s_axil_rresp_o),
	.core_rst_i (core_rst_o)
);

//--- test/io_hub_trace.txt
// op addr data strb exp_data exp_resp  (1 write, 2 read, 3 check outputs, 4 hold ready, 0 end)
// check: addr {pulse mask, pulse len}, data led, strb bit0 irq bit1 pulse, exp_data {clken, core_rst}
3 00000000 00000000 1 00060000 0  // after reset, irq low
1 FD0FFF00 000000A5 1 00000000 0  // led write
2 FD0FFF00 00000000 0 000000A5 0
3 00000000 000000A5 0 00060000 0
1 FD0FFF04 0000003C E 00000000 0  // lane 0 off, led kept
2 FD0FFF04 00000000 0 000000A5 0
1 FD0FFC00 00020000 C 00000000 0  // clken bits 2..0 = 010
2 FD0FFC00 00000000 0 00020000 0
1 FD0FFC00 00000030 3 00000000 0  // reset cores 4 and 5
3 00300040 000000A5 2 00060000 0  // 64 cycle pulse, clken bit 2 set
2 FD0FFC00 00000000 0 00060000 0
1 FD0FFC00 00050000 C 00000000 0  // upper lanes only
2 FD0FFC00 00000000 0 00050000 0
1 FD0FFC00 00010010 F 00000000 0  // both halves, load beats the set
3 00100040 000000A5 2 00010000 0
1 00001000 FFFFFFFF F 00000000 2  // unmapped
2 00001000 00000000 0 00000000 2
2 FD0FFE00 00000000 0 00000000 2  // page between the two
3 00000000 000000A5 0 00010000 0
4 00000000 00000000 0 00000000 0
2 FD0FFF00 00000000 0 000000A5 0  // rready held off
4 00000000 00000000 0 00000000 0
1 FD0FFF00 0000005A 1 00000000 0  // bready held off
2 FD0FFF00 00000000 0 0000005A 0
3 00000000 0000005A 0 00010000 0
0 00000000 00000000 0 00000000 0

//--- test/tb_io_hub.sv
`timescale 1ns/1ns

module tb_io_hub;
	import io_hub_pkg::*;

	localparam int TMR_PERIOD = 40;
	localparam int TMR_ON     = 6;
	localparam int TMR_OFF    = 14;
	localparam int MAX_REC    = 48;
	localparam int REC_W      = 6;	// words per trace record

	localparam logic [31:0] OP_END   = 32'd0;
	localparam logic [31:0] OP_WRITE = 32'd1;
	localparam logic [31:0] OP_READ  = 32'd2;
	localparam logic [31:0] OP_CHECK = 32'd3;
	localparam logic [31:0] OP_HOLD  = 32'd4;	// next bus op holds ready low

	logic       clk100;
	logic       rst;
	bus_addr_t  s_axil_awaddr;
	logic       s_axil_awvalid;
	logic       s_axil_awready;
	bus_data_t  s_axil_wdata;
	bus_strb_t  s_axil_wstrb;
	logic       s_axil_wvalid;
	logic       s_axil_wready;
	bus_resp_t  s_axil_bresp;
	logic       s_axil_bvalid;
	logic       s_axil_bready;
	bus_addr_t  s_axil_araddr;
	logic       s_axil_arvalid;
	logic       s_axil_arready;
	bus_data_t  s_axil_rdata;
	bus_resp_t  s_axil_rresp;
	logic       s_axil_rvalid;
	logic       s_axil_rready;
	led_t       led;
	core_mask_t core_rst;
	clken_t     clken;
	logic       tmr_irq;

	logic [31:0] trace_mem [0:MAX_REC*REC_W-1];
	int          n_rec;
	int          cycle_cnt   = 0;
	int          cycle_limit = 2000;	// raised once the trace is loaded
	logic        hold_next;
	// reset pulse bookkeeping from the falling edge monitor
	int          pulse_run   = 0;
	int          pulse_len   = 0;
	core_mask_t  pulse_seen  = '0;
	core_mask_t  pulse_mask  = '0;

	io_hub_top #(
		.RST_PULSE_LEN (64),
		.TMR_PERIOD    (TMR_PERIOD),
		.TMR_ON        (TMR_ON),
		.TMR_OFF       (TMR_OFF)
	) i_io_hub_top (
		.clk100           (clk100),
		.rst              (rst),
		.s_axil_awaddr_i  (s_axil_awaddr),
		.s_axil_awvalid_i (s_axil_awvalid),
		.s_axil_awready_o (s_axil_awready),
		.s_axil_wdata_i   (s_axil_wdata),
		.s_axil_wstrb_i   (s_axil_wstrb),
		.s_axil_wvalid_i  (s_axil_wvalid),
		.s_axil_wready_o  (s_axil_wready),
		.s_axil_bresp_o   (s_axil_bresp),
		.s_axil_bvalid_o  (s_axil_bvalid),
		.s_axil_bready_i  (s_axil_bready),
		.s_axil_araddr_i  (s_axil_araddr),
		.s_axil_arvalid_i (s_axil_arvalid),
		.s_axil_arready_o (s_axil_arready),
		.s_axil_rdata_o   (s_axil_rdata),
		.s_axil_rresp_o   (s_axil_rresp),
		.s_axil_rvalid_o  (s_axil_rvalid),
		.s_axil_rready_i  (s_axil_rready),
		.led_o            (led),
		.core_rst_o       (core_rst),
		.clken_o          (clken),
		.tmr_irq_o        (tmr_irq)
	);

	initial begin
		clk100 = 1'b0;
		forever #10 clk100 = ~clk100;	// 20 ns period
	end

	// --------------------------------------------------
	// watchdog and pulse monitor
	// --------------------------------------------------
	always @(posedge clk100) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			fail_run();
		end
	end

	always @(negedge clk100) begin
		if (core_rst != '0) begin
			pulse_run  = pulse_run + 1;
			pulse_seen = core_rst;
		end else if (pulse_run != 0) begin
			pulse_len  = pulse_run;	// run just ended
			pulse_mask = pulse_seen;
			pulse_run  = 0;
		end
	end

	task automatic fail_run();
		$display("Errors found");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_mismatch(input string what);
		$display("MISMATCH at time %0t: %s", $time, what);
		fail_run();
	endtask

	task automatic set_ready(input logic is_wr, input logic val);
		if (is_wr)
			s_axil_bready = val;
		else
			s_axil_rready = val;
	endtask

	// --------------------------------------------------
	// bus tasks start at a falling edge
	// --------------------------------------------------
	task automatic wait_response(input logic is_wr, input logic hold,
		output bus_data_t data, output bus_resp_t resp);
		logic      vld;
		int        hold_cycles;
		bus_data_t data0;
		bus_resp_t resp0;
		set_ready(is_wr, ~hold);
		vld = 1'b0;
		while (!vld) begin
			#1;	// let the response settle
			vld = is_wr ? s_axil_bvalid : s_axil_rvalid;
			if (!vld)
				@(negedge clk100);
		end
		data0 = is_wr ? 32'h0 : s_axil_rdata;
		resp0 = is_wr ? s_axil_bresp : s_axil_rresp;
		if (hold) begin
			hold_cycles = 1 + int'($urandom % 12);
			repeat (hold_cycles) begin
				@(negedge clk100);
				#1;
				vld = is_wr ? s_axil_bvalid : s_axil_rvalid;
				assert (vld && (is_wr ? s_axil_bresp : s_axil_rresp) == resp0
					&& (is_wr || s_axil_rdata == data0))
				else report_mismatch("response dropped or changed while ready was low");
			end
			@(negedge clk100);
			set_ready(is_wr, 1'b1);
		end
		@(negedge clk100);	// handshake done on the rising edge before
		set_ready(is_wr, 1'b0);
		data = data0;
		resp = resp0;
	endtask

	task automatic bus_write(input bus_addr_t addr, input bus_data_t data,
		input bus_strb_t strb, input logic hold, output bus_resp_t resp);
		logic      taken;
		bus_data_t unused;
		@(negedge clk100);
		s_axil_awaddr  = addr;
		s_axil_wdata   = data;
		s_axil_wstrb   = strb;
		s_axil_awvalid = 1'b1;
		s_axil_wvalid  = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			#1;
			taken = s_axil_awready & s_axil_wready;
			@(negedge clk100);
		end
		s_axil_awvalid = 1'b0;
		s_axil_wvalid  = 1'b0;
		wait_response(1'b1, hold, unused, resp);
	endtask

	task automatic bus_read(input bus_addr_t addr, input logic hold,
		output bus_data_t data, output bus_resp_t resp);
		logic taken;
		@(negedge clk100);
		s_axil_araddr  = addr;
		s_axil_arvalid = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			#1;
			taken = s_axil_arready;
			@(negedge clk100);
		end
		s_axil_arvalid = 1'b0;
		wait_response(1'b0, hold, data, resp);
	endtask

	// pulse_exp packs the pulse mask over the pulse length
	// regs_exp packs clken over core_rst
	task automatic check_outputs(input bus_addr_t pulse_exp, input bus_data_t led_exp,
		input bus_strb_t flags, input bus_data_t regs_exp, input logic irq_exp);
		@(negedge clk100);
		if (flags[1]) begin
			while (core_rst != '0)
				@(negedge clk100);
		end
		#1;
		assert (!s_axil_bvalid && !s_axil_rvalid && !s_axil_awready && !s_axil_wready
			&& !s_axil_arready)
		else report_mismatch("bus handshake outputs not idle");
		assert (led == led_exp[7:0])
		else report_mismatch($sformatf("led_o %h, expected %h", led, led_exp[7:0]));
		assert (clken == regs_exp[31:16])
		else report_mismatch($sformatf("clken_o %h, expected %h", clken, regs_exp[31:16]));
		assert (core_rst == regs_exp[15:0])
		else report_mismatch($sformatf("core_rst_o %h, expected %h", core_rst, regs_exp[15:0]));
		if (flags[0]) begin
			assert (tmr_irq == irq_exp)
			else report_mismatch($sformatf("tmr_irq_o %b, expected %b", tmr_irq, irq_exp));
		end
		if (flags[1]) begin
			assert (pulse_len == int'(pulse_exp[15:0]) && pulse_mask == pulse_exp[31:16])
			else report_mismatch($sformatf("reset pulse %h for %0d cycles, expected %h for %0d",
				pulse_mask, pulse_len, pulse_exp[31:16], pulse_exp[15:0]));
		end
	endtask

	task automatic run_record(input int r);
		logic [31:0] op;
		bus_addr_t   addr;
		bus_data_t   data;
		bus_strb_t   strb;
		bus_data_t   exp_data;
		bus_resp_t   exp_resp;
		bus_data_t   got_data;
		bus_resp_t   got_resp;
		op       = trace_mem[r*REC_W];
		addr     = trace_mem[r*REC_W+1];
		data     = trace_mem[r*REC_W+2];
		strb     = trace_mem[r*REC_W+3][3:0];
		exp_data = trace_mem[r*REC_W+4];
		exp_resp = trace_mem[r*REC_W+5][1:0];
		case (op)
		OP_WRITE: begin
			bus_write(addr, data, strb, hold_next, got_resp);
			hold_next = 1'b0;
			assert (got_resp == exp_resp)
			else report_mismatch($sformatf("record %0d write %h bresp %0d, expected %0d",
				r, addr, got_resp, exp_resp));
		end
		OP_READ: begin
			bus_read(addr, hold_next, got_data, got_resp);
			hold_next = 1'b0;
			assert (got_resp == exp_resp && got_data == exp_data)
			else report_mismatch($sformatf("record %0d read %h gave %h/%0d, expected %h/%0d",
				r, addr, got_data, got_resp, exp_data, exp_resp));
		end
		OP_CHECK: check_outputs(addr, data, strb, exp_data, exp_resp[0]);
		OP_HOLD:  hold_next = 1'b1;
		default: begin
			$display("trace record %0d has an unknown operation code %0h", r, op);
			fail_run();
		end
		endcase
	endtask

	// high and low phases counted between irq edges
	task automatic measure_timer();
		int hi;
		int lo;
		@(negedge clk100);
		while (tmr_irq)
			@(negedge clk100);
		while (!tmr_irq)
			@(negedge clk100);
		for (int p = 0; p < 3; p++) begin
			hi = 0;
			lo = 0;
			while (tmr_irq) begin
				hi = hi + 1;
				@(negedge clk100);
			end
			while (!tmr_irq) begin
				lo = lo + 1;
				@(negedge clk100);
			end
			assert (hi == TMR_OFF - TMR_ON && lo == TMR_PERIOD - (TMR_OFF - TMR_ON))
			else report_mismatch($sformatf("timer period %0d high %0d low %0d", p, hi, lo));
		end
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		void'($urandom(32'h270));
		rst            = 1'b1;
		s_axil_awaddr  = '0;
		s_axil_awvalid = 1'b0;
		s_axil_wdata   = '0;
		s_axil_wstrb   = '0;
		s_axil_wvalid  = 1'b0;
		s_axil_bready  = 1'b0;
		s_axil_araddr  = '0;
		s_axil_arvalid = 1'b0;
		s_axil_rready  = 1'b0;
		hold_next      = 1'b0;
		$readmemh("test/io_hub_trace.txt", trace_mem);
		n_rec = 0;
		while (n_rec < MAX_REC && trace_mem[n_rec*REC_W] != OP_END)
			n_rec = n_rec + 1;
		cycle_limit = n_rec * 100 + 2000;
		repeat (16) @(negedge clk100);
		rst = 1'b0;
		for (int i = 0; i < n_rec; i++)
			run_record(i);
		measure_timer();
		$display("No errors");
		$finish;
	end

endmodule
